/* build.f */
+incdir+hw
hw/ooo_pkg.sv
hw/cdb_if.sv
hw/reorder_buffer.sv
hw/rename_regfile.sv
hw/alu_station.sv
hw/ooo_core.sv
tb/ooo_asserts.sv
tb/ooo_checker.sv
tb/ooo_tb.sv

/* tb/ooo_tb.sv */
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_tb;

    localparam int NUM_INSTR      = 200;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 100;

    logic                 clk;
    logic                 rst;
    logic                 issue_req;
    logic                 issue_ack;
    ooo_pkg::alu_op_t     issue_op;
    logic [4:0]           issue_rd;
    logic [4:0]           issue_rs1;
    logic [4:0]           issue_rs2;
    logic                 issue_use_imm;
    logic [`OOO_XLEN-1:0] issue_imm;
    logic                 commit_valid;
    ooo_pkg::rob_tag_t    commit_tag;
    logic [4:0]           commit_rd;
    logic [`OOO_XLEN-1:0] commit_value;
    logic                 commit_branch;
    logic                 commit_taken;

    int seed;
    int gap;
    int cycle_count;
    int stall_cycles;
    int assert_fails;
    int error_count;
    int check_count;
    int accept_count;
    int commit_count;

    ooo_core DUT (
        .clk           (clk),
        .rst           (rst),
        .issue_req     (issue_req),
        .issue_ack     (issue_ack),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_use_imm (issue_use_imm),
        .issue_imm     (issue_imm),
        .commit_valid  (commit_valid),
        .commit_tag    (commit_tag),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .commit_branch (commit_branch),
        .commit_taken  (commit_taken)
    );

    ooo_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .issue_req     (issue_req),
        .issue_ack     (issue_ack),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_use_imm (issue_use_imm),
        .issue_imm     (issue_imm),
        .commit_valid  (commit_valid),
        .commit_tag    (commit_tag),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .commit_branch (commit_branch),
        .commit_taken  (commit_taken),
        .error_count   (error_count),
        .check_count   (check_count),
        .accept_count  (accept_count),
        .commit_count  (commit_count)
    );

    always #5 clk = ~clk;

    // mostly x0..x3, so that chains and rewrites of one register are common.
    task automatic pick_register(output logic [4:0] r);
        int k;
        k = $unsigned($random(seed)) % 8;
        if (k < 6) begin
            r = 5'(k % 4);
        end else begin
            r = 5'($unsigned($random(seed)) % 32);
        end
    endtask

    task automatic load_random_instruction();
        int k;
        k = $unsigned($random(seed)) % 13;
        issue_op = ooo_pkg::alu_op_t'(k);
        pick_register(issue_rd);
        pick_register(issue_rs1);
        pick_register(issue_rs2);
        issue_use_imm = $random(seed) & 1;
        if ($random(seed) & 1) begin
            issue_imm = $random(seed) % 16;  // small, either sign.
        end else begin
            issue_imm = $random(seed);
        end
    endtask

    // four-phase handshake, called on a falling edge.
    task automatic send_instruction();
        load_random_instruction();
        issue_req = 1'b1;
        @(negedge clk);
        while (!issue_ack) begin
            stall_cycles++;
            @(negedge clk);
        end
        issue_req = 1'b0;
        while (issue_ack) begin
            @(negedge clk);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed          = 87;
        stall_cycles  = 0;
        assert_fails  = 0;
        clk           = 1'b0;
        rst           = 1'b0;
        issue_req     = 1'b0;
        issue_op      = ooo_pkg::OP_ADD;
        issue_rd      = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_use_imm = 1'b0;
        issue_imm     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
            send_instruction();
        end
        while (commit_count < accept_count) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);  // a stray extra commit would show here.
        assert_fails = DUT.u_asserts.fail_count;
        $display("checks %0d, errors %0d, asserts %0d, accepted %0d, committed %0d, stalls %0d",
                 check_count, error_count, assert_fails, accept_count, commit_count,
                 stall_cycles);
        if (error_count == 0 && assert_fails == 0 && accept_count == NUM_INSTR &&
            commit_count == NUM_INSTR) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/ooo_checker.sv */
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_req,
    input  logic                 issue_ack,
    input  ooo_pkg::alu_op_t     issue_op,
    input  logic [4:0]           issue_rd,
    input  logic [4:0]           issue_rs1,
    input  logic [4:0]           issue_rs2,
    input  logic                 issue_use_imm,
    input  logic [`OOO_XLEN-1:0] issue_imm,
    input  logic                 commit_valid,
    input  ooo_pkg::rob_tag_t    commit_tag,
    input  logic [4:0]           commit_rd,
    input  logic [`OOO_XLEN-1:0] commit_value,
    input  logic                 commit_branch,
    input  logic                 commit_taken,
    output int                   error_count,
    output int                   check_count,
    output int                   accept_count,
    output int                   commit_count
);

    typedef struct packed {
        ooo_pkg::rob_tag_t    tag;
        logic [4:0]           rd;
        logic [`OOO_XLEN-1:0] value;
        logic                 branch;
        logic                 taken;
    } expect_t;

    logic [`OOO_XLEN-1:0] model [32];  // architectural state, in program order.
    expect_t              want_q [$];
    expect_t              want;
    ooo_pkg::rob_tag_t    next_tag;
    logic                 ack_q;
    logic                 req_seen;

    function automatic expect_t reference_result(
        input ooo_pkg::alu_op_t     op,
        input logic [`OOO_XLEN-1:0] a,
        input logic [`OOO_XLEN-1:0] b_reg,
        input logic [`OOO_XLEN-1:0] imm,
        input logic                 use_imm,
        input logic [4:0]           rd,
        input ooo_pkg::rob_tag_t    tag
    );
        expect_t              e;
        logic [`OOO_XLEN-1:0] b;
        e.tag    = tag;
        e.rd     = rd;
        e.value  = '0;
        e.branch = 1'b0;
        e.taken  = 1'b0;
        b        = use_imm ? imm : b_reg;
        case (op)
            ooo_pkg::OP_ADD:  e.value = a + b;
            ooo_pkg::OP_SUB:  e.value = a - b;
            ooo_pkg::OP_AND:  e.value = a & b;
            ooo_pkg::OP_OR:   e.value = a | b;
            ooo_pkg::OP_XOR:  e.value = a ^ b;
            ooo_pkg::OP_SLT:  e.value = ($signed(a) < $signed(b)) ? 1 : 0;
            ooo_pkg::OP_SLTU: e.value = (a < b) ? 1 : 0;
            ooo_pkg::OP_SLL:  e.value = a << b[4:0];
            ooo_pkg::OP_SRL:  e.value = a >> b[4:0];
            ooo_pkg::OP_LUI:  e.value = imm;
            ooo_pkg::OP_BEQ: begin
                e.branch = 1'b1;
                e.taken  = (a == b_reg);  // branches always compare two registers.
            end
            ooo_pkg::OP_BNE: begin
                e.branch = 1'b1;
                e.taken  = (a != b_reg);
            end
            ooo_pkg::OP_BLT: begin
                e.branch = 1'b1;
                e.taken  = ($signed(a) < $signed(b_reg));
            end
            default: e.value = '0;
        endcase
        if (e.branch) begin
            e.rd = '0;
        end
        return e;
    endfunction

    task automatic compare_field(input string what, input logic [`OOO_XLEN-1:0] got,
                                 input logic [`OOO_XLEN-1:0] exp_val);
        check_count++;
        if (got !== exp_val) begin
            error_count++;
            $display("FAIL %0t: commit %0d %s is 0x%0h, expected 0x%0h",
                     $time, commit_count, what, got, exp_val);
        end
    endtask

    initial begin
        error_count  = 0;
        check_count  = 0;
        accept_count = 0;
        commit_count = 0;
        next_tag     = 3'd1;
        ack_q        = 1'b0;
        req_seen     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            ack_q = 1'b0;
        end else begin
            if (!req_seen && (issue_ack || commit_valid)) begin
                error_count++;
                $display("output active before the first request at time %0t", $time);
            end
            if (issue_req) begin
                req_seen = 1'b1;
            end
            if (issue_ack && !ack_q) begin  // fields are held until ack falls.
                want = reference_result(issue_op, model[issue_rs1], model[issue_rs2],
                                        issue_imm, issue_use_imm, issue_rd, next_tag);
                if (!want.branch && issue_rd != 5'd0) begin
                    model[issue_rd] = want.value;
                end
                want_q.push_back(want);
                accept_count++;
                next_tag = (next_tag == 3'd7) ? 3'd1 : next_tag + 3'd1;
            end
            ack_q = issue_ack;
            if (commit_valid) begin
                commit_count++;
                if (want_q.size() == 0) begin
                    error_count++;
                    $display("commit with no outstanding instruction at time %0t", $time);
                end else begin
                    want = want_q.pop_front();
                    compare_field("tag", `OOO_XLEN'(commit_tag), `OOO_XLEN'(want.tag));
                    compare_field("rd", `OOO_XLEN'(commit_rd), `OOO_XLEN'(want.rd));
                    compare_field("value", commit_value, want.value);
                    compare_field("branch", `OOO_XLEN'(commit_branch), `OOO_XLEN'(want.branch));
                    compare_field("taken", `OOO_XLEN'(commit_taken), `OOO_XLEN'(want.taken));
                end
            end
        end
    end

endmodule

/* tb/ooo_asserts.sv */
`timescale 1ns/100ps

module ooo_asserts (
    input logic              clk,
    input logic              rst,
    input logic              issue_req,
    input logic              issue_ack,
    input logic              bus_valid,
    input ooo_pkg::rob_tag_t bus_tag
);

    int fail_count = 0;

    // ack is raised on the dispatch edge, which needs a live request.
    ack_rise: assert property (@(posedge clk) disable iff (!rst)
        $rose(issue_ack) |-> $past(issue_req))
        else begin
            fail_count++;
            $error("issue_ack rose without a pending request");
        end

    ack_fall: assert property (@(posedge clk) disable iff (!rst)
        $fell(issue_ack) |-> !$past(issue_req))
        else begin
            fail_count++;
            $error("issue_ack fell while the request was still high");
        end

    bus_tag_nonzero: assert property (@(posedge clk) disable iff (!rst)
        bus_valid |-> bus_tag != '0)
        else begin
            fail_count++;
            $error("result bus valid with tag 0");
        end

endmodule

bind ooo_core ooo_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .issue_req (issue_req),
    .issue_ack (issue_ack),
    .bus_valid (cdb.valid),
    .bus_tag   (cdb.tag)
);

/* hw/ooo_core.sv */
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_req,
    output logic                 issue_ack,
    input  ooo_pkg::alu_op_t     issue_op,
    input  logic [4:0]           issue_rd,
    input  logic [4:0]           issue_rs1,
    input  logic [4:0]           issue_rs2,
    input  logic                 issue_use_imm,
    input  logic [`OOO_XLEN-1:0] issue_imm,
    output logic                 commit_valid,
    output ooo_pkg::rob_tag_t    commit_tag,
    output logic [4:0]           commit_rd,
    output logic [`OOO_XLEN-1:0] commit_value,
    output logic                 commit_branch,
    output logic                 commit_taken
);

    cdb_if cdb ();

    logic               rob_full;
    logic               rs_space;
    logic               is_lui;
    logic               is_br;
    logic               dispatch;
    logic [4:0]         dest_rd;
    ooo_pkg::rob_tag_t  alloc_tag;
    ooo_pkg::operand_t  rf1;
    ooo_pkg::operand_t  rf2;
    ooo_pkg::operand_t  fwd1;
    ooo_pkg::operand_t  fwd2;
    ooo_pkg::dispatch_t disp;

    assign is_lui   = (issue_op == ooo_pkg::OP_LUI);
    assign is_br    = ooo_pkg::is_branch(issue_op);
    assign dest_rd  = is_br ? 5'd0 : issue_rd;  // branches write no register.
    assign dispatch = issue_req && !issue_ack && !rob_full && (is_lui || rs_space);

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_ack <= 1'b0;
        end else if (dispatch) begin
            issue_ack <= 1'b1;
        end else if (!issue_req) begin
            issue_ack <= 1'b0;
        end
    end

    always_comb begin
        disp.op   = issue_op;
        disp.dest = alloc_tag;
        disp.src1 = (rf1.tag == '0) ? rf1 : fwd1;
        disp.src2 = (rf2.tag == '0) ? rf2 : fwd2;
        disp.imm  = issue_imm;
        if (issue_use_imm && !is_br) begin
            disp.src2.value = issue_imm;
            disp.src2.tag   = '0;
        end
    end

    reorder_buffer u_rob (
        .clk           (clk),
        .rst           (rst),
        .alloc         (dispatch),
        .alloc_op      (disp.op),
        .alloc_rd      (dest_rd),
        .alloc_imm     (disp.imm),
        .query1        (rf1.tag),
        .query2        (rf2.tag),
        .alloc_tag     (alloc_tag),
        .full          (rob_full),
        .fwd1          (fwd1),
        .fwd2          (fwd2),
        .commit_valid  (commit_valid),
        .commit_tag    (commit_tag),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .commit_branch (commit_branch),
        .commit_taken  (commit_taken),
        .cdb           (cdb.listener)
    );

    rename_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1        (issue_rs1),
        .rs2        (issue_rs2),
        .rename     (dispatch),
        .rename_rd  (dest_rd),
        .rename_tag (alloc_tag),
        .wr_en      (commit_valid),
        .wr_rd      (commit_rd),
        .wr_tag     (commit_tag),
        .wr_value   (commit_value),
        .rd1        (rf1),
        .rd2        (rf2)
    );

    // lui never enters the station.
    alu_station u_station (
        .clk     (clk),
        .rst     (rst),
        .accept  (dispatch && !is_lui),
        .entry   (disp),
        .space   (rs_space),
        .cdb_drv (cdb.producer),
        .cdb     (cdb.listener)
    );

endmodule

/* hw/alu_station.sv */
`timescale 1ns/100ps
`include "ooo_macros.svh"

module alu_station (
    input  logic               clk,
    input  logic               rst,
    input  logic               accept,
    input  ooo_pkg::dispatch_t entry,
    output logic               space,
    cdb_if.producer            cdb_drv,
    cdb_if.listener            cdb
);

    localparam int DEPTH = `OOO_RS_DEPTH;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    ooo_pkg::dispatch_t   ent     [DEPTH];
    logic [IDX_W-1:0]     ent_age [DEPTH];  // higher is older.
    logic [DEPTH-1:0]     ent_valid;
    logic [IDX_W-1:0]     sel;
    logic                 sel_found;
    logic [IDX_W-1:0]     free_idx;
    logic [`OOO_XLEN-1:0] a;
    logic [`OOO_XLEN-1:0] b;
    logic [`OOO_XLEN-1:0] alu_out;
    logic                 cond;

    always_comb begin
        sel_found = 1'b0;
        sel       = '0;
        space     = 1'b0;
        free_idx  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_valid[i] && ent[i].src1.tag == '0 && ent[i].src2.tag == '0 &&
                (!sel_found || ent_age[i] > ent_age[sel])) begin
                sel_found = 1'b1;
                sel       = IDX_W'(i);
            end
            if (!ent_valid[i] && !space) begin
                space    = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        a       = ent[sel].src1.value;
        b       = ent[sel].src2.value;
        alu_out = '0;
        cond    = 1'b0;
        case (ent[sel].op)
            ooo_pkg::OP_ADD:  alu_out = a + b;
            ooo_pkg::OP_SUB:  alu_out = a - b;
            ooo_pkg::OP_AND:  alu_out = a & b;
            ooo_pkg::OP_OR:   alu_out = a | b;
            ooo_pkg::OP_XOR:  alu_out = a ^ b;
            ooo_pkg::OP_SLT:  alu_out = `OOO_XLEN'($signed(a) < $signed(b));
            ooo_pkg::OP_SLTU: alu_out = `OOO_XLEN'(a < b);
            ooo_pkg::OP_SLL:  alu_out = a << b[4:0];
            ooo_pkg::OP_SRL:  alu_out = a >> b[4:0];
            ooo_pkg::OP_BEQ:  cond = (a == b);
            ooo_pkg::OP_BNE:  cond = (a != b);
            ooo_pkg::OP_BLT:  cond = ($signed(a) < $signed(b));
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ent_valid     <= '0;
            cdb_drv.valid <= 1'b0;
        end else begin
            if (sel_found) begin
                ent_valid[sel] <= 1'b0;  // freed as it issues.
            end
            if (accept) begin
                ent_valid[free_idx] <= 1'b1;
            end
            cdb_drv.valid <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (cdb.valid && ent[i].src1.tag != '0 && ent[i].src1.tag == cdb.tag) begin
                ent[i].src1.value <= cdb.value;
                ent[i].src1.tag   <= '0;
            end
            if (cdb.valid && ent[i].src2.tag != '0 && ent[i].src2.tag == cdb.tag) begin
                ent[i].src2.value <= cdb.value;
                ent[i].src2.tag   <= '0;
            end
            if (accept && ent_valid[i] && ent_age[i] != IDX_W'(DEPTH - 1)) begin
                ent_age[i] <= ent_age[i] + 1'b1;
            end
        end
        if (accept) begin
            ent[free_idx]     <= entry;
            ent_age[free_idx] <= '0;
        end
        cdb_drv.tag   <= ent[sel].dest;
        cdb_drv.value <= ooo_pkg::is_branch(ent[sel].op) ? '0 : alu_out;
        cdb_drv.taken <= ooo_pkg::is_branch(ent[sel].op) && cond;
    end

endmodule

/* hw/rename_regfile.sv */
`timescale 1ns/100ps
`include "ooo_macros.svh"

module rename_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  logic                 rename,
    input  logic [4:0]           rename_rd,
    input  ooo_pkg::rob_tag_t    rename_tag,
    input  logic                 wr_en,
    input  logic [4:0]           wr_rd,
    input  ooo_pkg::rob_tag_t    wr_tag,
    input  logic [`OOO_XLEN-1:0] wr_value,
    output ooo_pkg::operand_t    rd1,
    output ooo_pkg::operand_t    rd2
);

    logic [`OOO_XLEN-1:0] regs [32];
    ooo_pkg::rob_tag_t    tags [32];

    always_comb begin
        rd1.value = regs[rs1];
        rd1.tag   = tags[rs1];
        rd2.value = regs[rs2];
        rd2.tag   = tags[rs2];
        if (rs1 == 5'd0) begin
            rd1.value = '0;
            rd1.tag   = '0;
        end
        if (rs2 == 5'd0) begin
            rd2.value = '0;
            rd2.tag   = '0;
        end
    end

    // architectural state starts at zero.
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (wr_en && wr_rd != 5'd0) begin
                regs[wr_rd] <= wr_value;
                if (tags[wr_rd] == wr_tag) begin
                    tags[wr_rd] <= '0;  // only the newest producer clears it.
                end
            end
            if (rename && rename_rd != 5'd0) begin
                tags[rename_rd] <= rename_tag;  // overrides a same-cycle clear.
            end
        end
    end

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/100ps
`include "ooo_macros.svh"

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,
    input  ooo_pkg::alu_op_t     alloc_op,
    input  logic [4:0]           alloc_rd,
    input  logic [`OOO_XLEN-1:0] alloc_imm,
    input  ooo_pkg::rob_tag_t    query1,
    input  ooo_pkg::rob_tag_t    query2,
    output ooo_pkg::rob_tag_t    alloc_tag,
    output logic                 full,
    output ooo_pkg::operand_t    fwd1,
    output ooo_pkg::operand_t    fwd2,
    output logic                 commit_valid,
    output ooo_pkg::rob_tag_t    commit_tag,
    output logic [4:0]           commit_rd,
    output logic [`OOO_XLEN-1:0] commit_value,
    output logic                 commit_branch,
    output logic                 commit_taken,
    cdb_if.listener              cdb
);

    localparam int DEPTH = `OOO_ROB_DEPTH;

    ooo_pkg::alu_op_t     slot_op    [DEPTH];
    logic [4:0]           slot_rd    [DEPTH];
    logic [`OOO_XLEN-1:0] slot_value [DEPTH];
    logic                 slot_taken [DEPTH];
    logic [DEPTH-1:0]     slot_done;

    ooo_pkg::rob_tag_t head;
    ooo_pkg::rob_tag_t tail;
    ooo_pkg::rob_tag_t count;
    logic              retire;

    // tags run 1 .. DEPTH-1 and wrap back to 1.
    function automatic ooo_pkg::rob_tag_t next_tag(input ooo_pkg::rob_tag_t t);
        if (t == ooo_pkg::rob_tag_t'(DEPTH - 1)) begin
            return ooo_pkg::rob_tag_t'(1);
        end
        return t + ooo_pkg::rob_tag_t'(1);
    endfunction

    // done slot first, then a result on the bus this cycle.
    function automatic ooo_pkg::operand_t resolve(input ooo_pkg::rob_tag_t q);
        ooo_pkg::operand_t r;
        r.value = '0;
        r.tag   = q;
        if (q != '0) begin
            if (slot_done[q]) begin
                r.value = slot_value[q];
                r.tag   = '0;
            end else if (cdb.valid && cdb.tag == q) begin
                r.value = cdb.value;
                r.tag   = '0;
            end
        end
        return r;
    endfunction

    assign alloc_tag = tail;
    assign full      = (count == ooo_pkg::rob_tag_t'(DEPTH - 1));
    assign retire    = (count != '0) && slot_done[head];

    always_comb begin
        fwd1 = resolve(query1);
        fwd2 = resolve(query2);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= ooo_pkg::rob_tag_t'(1);
            tail         <= ooo_pkg::rob_tag_t'(1);
            count        <= '0;
            slot_done    <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (cdb.valid) begin
                slot_done[cdb.tag] <= 1'b1;
            end
            if (alloc) begin
                slot_done[tail] <= (alloc_op == ooo_pkg::OP_LUI);  // lui finishes at dispatch.
                tail            <= next_tag(tail);
            end
            if (retire) begin
                head <= next_tag(head);
            end
            count        <= count + ooo_pkg::rob_tag_t'(alloc) - ooo_pkg::rob_tag_t'(retire);
            commit_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            slot_value[cdb.tag] <= cdb.value;
            slot_taken[cdb.tag] <= cdb.taken;
        end
        if (alloc) begin
            slot_op[tail]    <= alloc_op;
            slot_rd[tail]    <= alloc_rd;
            slot_value[tail] <= alloc_imm;
            slot_taken[tail] <= 1'b0;
        end
        if (retire) begin
            commit_tag    <= head;
            commit_rd     <= slot_rd[head];
            commit_value  <= slot_value[head];
            commit_branch <= ooo_pkg::is_branch(slot_op[head]);
            commit_taken  <= slot_taken[head];
        end
    end

endmodule

/* hw/cdb_if.sv */
`timescale 1ns/100ps
`include "ooo_macros.svh"

interface cdb_if;

    logic                 valid;
    ooo_pkg::rob_tag_t    tag;
    logic [`OOO_XLEN-1:0] value;
    logic                 taken;  // branch outcome, value is 0 then.

    modport producer (
        output valid,
        output tag,
        output value,
        output taken
    );

    modport listener (
        input valid,
        input tag,
        input value,
        input taken
    );

endinterface

/* hw/ooo_pkg.sv */
`include "ooo_macros.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLTU = 4'd6,
        OP_SLL  = 4'd7,
        OP_SRL  = 4'd8,
        OP_LUI  = 4'd9,  // result is the immediate as given.
        OP_BEQ  = 4'd10,
        OP_BNE  = 4'd11,
        OP_BLT  = 4'd12
    } alu_op_t;

    // 0 means the value is present.
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;

    typedef struct packed {
        logic [`OOO_XLEN-1:0] value;  // valid only when tag is 0.
        rob_tag_t             tag;
    } operand_t;

    typedef struct packed {
        alu_op_t              op;
        rob_tag_t             dest;
        operand_t             src1;
        operand_t             src2;
        logic [`OOO_XLEN-1:0] imm;
    } dispatch_t;

    function automatic logic is_branch(input alu_op_t op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT};
    endfunction

endpackage

/* hw/ooo_macros.svh */
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// datapath width.
`define OOO_XLEN 32

// slot 0 is the "no producer" tag, so one fewer slot is usable.
`define OOO_ROB_DEPTH 8

`define OOO_RS_DEPTH 2

`endif
